// File: tile_perf_monitor.f
src/perf_pkg.sv
src/perf_event_sample.sv
src/perf_stall_classify.sv
src/perf_counter_bank.sv
src/perf_report_seq.sv
src/tile_perf_monitor.sv
sim/tile_perf_monitor_checker.sv
sim/tb_tile_perf_monitor.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_tile_perf_monitor \
  -f tile_perf_monitor.f
./obj_dir/Vtb_tile_perf_monitor > sim.log 2>&1
cat sim.log
if grep -qx "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: sim/perf_stim.txt
# S test cycles freeze imem dmem_wait dmem_en rsrv dx redirect in_full out_full
# D test cycles dmem rsrv dx redirect imem in_full out_full (expected counts)
D 1 0 0 0 0 0 0 0 0
S 2 4 0 0 0 0 0 0 0 0 0
S 2 5 0 1 0 0 0 0 0 0 0
S 2 3 0 0 0 0 0 0 0 1 0
S 2 6 0 0 0 0 0 0 0 0 1
S 2 2 0 1 0 0 0 0 0 1 1
S 2 2 1 0 0 0 0 0 0 0 0
D 2 19 0 0 0 0 7 5 8
S 3 2 0 0 0 0 0 0 0 0 0
S 3 4 0 1 1 1 1 1 1 0 0
S 3 3 0 0 0 0 1 1 1 0 0
S 3 5 0 0 0 0 0 1 1 0 0
S 3 2 0 0 0 0 0 0 1 0 0
S 3 3 0 0 1 0 1 1 0 0 0
S 3 2 0 0 1 0 0 0 1 0 0
S 3 2 0 0 0 1 0 1 0 0 0
S 3 2 1 0 0 0 0 0 0 0 0
D 3 22 4 6 7 4 4 0 0
S 4 3 0 0 0 0 0 0 0 1 0
S 4 4 1 1 1 1 1 1 1 1 1
S 4 3 0 0 0 0 1 0 0 0 0
S 4 2 0 0 0 0 0 0 0 0 1
S 4 2 1 1 0 0 0 0 0 0 0
D 4 4 0 2 0 0 0 0 2
S 5 1 0 0 0 0 0 0 0 0 0
S 5 10 0 1 1 1 0 0 0 1 0
S 5 7 0 0 0 0 0 1 1 0 1
S 5 1 1 0 0 0 0 0 0 0 0
D 5 17 10 0 7 0 10 10 7
D 6 17 10 0 7 0 10 10 7

// File: sim/tb_tile_perf_monitor.sv
`timescale 1ns/1ps

module tb_tile_perf_monitor;

  localparam int WAIT_LIMIT = 20; // cycles

  logic clk_i;
  logic rst_n_i;
  logic freeze_i;
  logic imem_wait_i;
  logic dmem_wait_i;
  logic dmem_en_i;
  logic rsrv_stall_i;
  logic dx_stall_i;
  logic redirect_i;
  logic in_full_i;
  logic out_full_i;
  logic dump_i;
  logic rpt_v_o;
  perf_pkg::perf_ctr_e rpt_id_o;
  logic [perf_pkg::CNT_W_DEFAULT-1:0] rpt_count_o;

  logic [perf_pkg::CNT_W_DEFAULT-1:0] exp_cnt [perf_pkg::NUM_CTRS];
  logic lvl [9]; // freeze, then the eight status levels in file order
  int   tests_run;
  int   tests_failed;
  int   errors;
  int   test_errors;

  tile_perf_monitor uut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic apply_levels(input int cycles);
    int i;
    for (i = 0; i < cycles; i++)
    begin
      @(posedge clk_i);
      freeze_i     <= lvl[0];
      imem_wait_i  <= lvl[1];
      dmem_wait_i  <= lvl[2];
      dmem_en_i    <= lvl[3];
      rsrv_stall_i <= lvl[4];
      dx_stall_i   <= lvl[5];
      redirect_i   <= lvl[6];
      in_full_i    <= lvl[7];
      out_full_i   <= lvl[8];
    end
  endtask

  task automatic wait_valid(output logic seen);
    int waited;
    waited = 0;
    while (!rpt_v_o && waited < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      waited++;
    end
    seen = rpt_v_o;
  endtask

  task automatic check_beat(input int beat);
    perf_pkg::perf_ctr_e exp_id;
    exp_id = perf_pkg::perf_ctr_e'(beat[perf_pkg::CTR_ID_W-1:0]);
    assert (rpt_id_o == exp_id)
    else
    begin
      $display("CHECK FAILED at time %0t: rpt_id_o expected %0d got %0d",
               $time, exp_id, rpt_id_o);
      test_errors++;
    end
    assert (rpt_count_o == exp_cnt[beat])
    else
    begin
      $display("CHECK FAILED at time %0t: rpt_count_o[%0d] expected %0d got %0d",
               $time, beat, exp_cnt[beat], rpt_count_o);
      test_errors++;
    end
  endtask

  task automatic run_dump(input int test_no);
    int   beat;
    int   i;
    logic seen;
    for (i = 1; i < 9; i++)
      lvl[i] = 1'b0;
    apply_levels(3); // let the pipeline drain
    @(posedge clk_i);
    dump_i <= 1'b1;
    @(posedge clk_i);
    dump_i <= 1'b0;
    @(negedge clk_i);
    seen = 1'b1;
    for (beat = 0; beat < perf_pkg::NUM_CTRS && seen; beat++)
    begin
      wait_valid(seen);
      if (!seen)
      begin
        $display("timeout in test %0d: readout beat %0d never arrived", test_no, beat);
        test_errors++;
      end
      else
      begin
        check_beat(beat);
        @(posedge clk_i);
        dump_i <= (beat == 2); // extra dump that lands mid readout
        @(negedge clk_i);
      end
    end
    for (i = 0; i < 4 && seen; i++)
    begin
      assert (!rpt_v_o)
      else
      begin
        $display("CHECK FAILED at time %0t: rpt_v_o expected 0 got %0b", $time, rpt_v_o);
        test_errors++;
      end
      @(negedge clk_i);
    end
  endtask

  initial
  begin
    int fd;
    int code;
    int test_no;
    int count;
    int val;
    int i;
    logic done;
    logic [63:0] kind;
    logic [8*128-1:0] rest;
    rst_n_i      = 1'b0;
    freeze_i     = 1'b1;
    imem_wait_i  = 1'b0;
    dmem_wait_i  = 1'b0;
    dmem_en_i    = 1'b0;
    rsrv_stall_i = 1'b0;
    dx_stall_i   = 1'b0;
    redirect_i   = 1'b0;
    in_full_i    = 1'b0;
    out_full_i   = 1'b0;
    dump_i       = 1'b0;
    lvl[0]       = 1'b1;
    for (i = 1; i < 9; i++)
      lvl[i] = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    fd = $fopen("sim/perf_stim.txt", "r");
    done = (fd == 0);
    if (fd == 0)
    begin
      $display("could not open the stimulus file sim/perf_stim.txt");
      errors++;
    end
    while (!done)
    begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1)
        done = 1'b1;
      else if (kind == "#")
        code = $fgets(rest, fd);
      else if (kind == "S")
      begin
        code = $fscanf(fd, "%d %d", test_no, count);
        for (i = 0; i < 9; i++)
        begin
          code = $fscanf(fd, "%d", val);
          lvl[i] = (val != 0);
        end
        apply_levels(count);
      end
      else if (kind == "D")
      begin
        code = $fscanf(fd, "%d", test_no);
        for (i = 0; i < perf_pkg::NUM_CTRS; i++)
          code = $fscanf(fd, "%d", exp_cnt[i]);
        test_errors = 0;
        run_dump(test_no);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0)
          $display("test %0d: pass", test_no);
        else
        begin
          tests_failed++;
          $display("test %0d: FAIL with %0d errors", test_no, test_errors);
        end
      end
      else
      begin
        $display("unknown line kind in the stimulus file after test %0d", test_no);
        errors++;
        done = 1'b1;
      end
    end
    if (fd != 0)
      $fclose(fd);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run > 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: sim/tile_perf_monitor_checker.sv
`timescale 1ns/1ps

module tile_perf_monitor_checker
(
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic                          rpt_v_i,
  input logic [perf_pkg::CTR_ID_W-1:0] rpt_id_i
);

  logic [3:0] v_run; // valid cycles in a row so far

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      v_run <= 4'd0;
    else if (!rpt_v_i)
      v_run <= 4'd0;
    else if (v_run != 4'hf)
      v_run <= v_run + 4'd1;
  end

  idle_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |=> !rpt_v_i)
    else $error("readout valid in the cycle after reset release");

  first_beat_cycles: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(rpt_v_i) |-> rpt_id_i == perf_pkg::CTR_CYCLES)
    else $error("readout does not start with the cycle counter");

  id_steps: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rpt_v_i && $past(rpt_v_i) |-> rpt_id_i == $past(rpt_id_i) + 3'd1)
    else $error("counter id did not step by one between beats");

  burst_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rpt_v_i |-> v_run < 4'd8)
    else $error("readout valid for more than eight cycles");

endmodule

bind tile_perf_monitor tile_perf_monitor_checker u_checker
(
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .rpt_v_i  (rpt_v_o),
  .rpt_id_i (rpt_id_o)
);

// File: src/tile_perf_monitor.sv
`timescale 1ns/1ps

module tile_perf_monitor
#(
  parameter int cnt_w = perf_pkg::CNT_W_DEFAULT
)
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                freeze_i,
  input  logic                imem_wait_i,
  input  logic                dmem_wait_i,
  input  logic                dmem_en_i,
  input  logic                rsrv_stall_i,
  input  logic                dx_stall_i,
  input  logic                redirect_i,
  input  logic                in_full_i,
  input  logic                out_full_i,
  input  logic                dump_i,
  output logic                rpt_v_o,
  output perf_pkg::perf_ctr_e rpt_id_o,
  output logic [cnt_w-1:0]    rpt_count_o
);

  logic imem_wait_s;
  logic dmem_wait_s;
  logic dmem_en_s;
  logic rsrv_stall_s;
  logic dx_stall_s;
  logic redirect_s;
  logic in_full_s;
  logic out_full_s;
  logic cnt_en;
  logic clr_s1; // clear out of stage 1
  logic clr_s2; // clear out of stage 2

  logic [perf_pkg::NUM_CTRS-1:0] inc;
  perf_pkg::perf_ctr_e           rd_id;
  logic [cnt_w-1:0]              rd_count;

  perf_event_sample u_sample
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .freeze_i       (freeze_i),
    .imem_wait_i    (imem_wait_i),
    .dmem_wait_i    (dmem_wait_i),
    .dmem_en_i      (dmem_en_i),
    .rsrv_stall_i   (rsrv_stall_i),
    .dx_stall_i     (dx_stall_i),
    .redirect_i     (redirect_i),
    .in_full_i      (in_full_i),
    .out_full_i     (out_full_i),
    .imem_wait_s_o  (imem_wait_s),
    .dmem_wait_s_o  (dmem_wait_s),
    .dmem_en_s_o    (dmem_en_s),
    .rsrv_stall_s_o (rsrv_stall_s),
    .dx_stall_s_o   (dx_stall_s),
    .redirect_s_o   (redirect_s),
    .in_full_s_o    (in_full_s),
    .out_full_s_o   (out_full_s),
    .cnt_en_o       (cnt_en),
    .clr_o          (clr_s1)
  );

  perf_stall_classify u_classify
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .imem_wait_s_i  (imem_wait_s),
    .dmem_wait_s_i  (dmem_wait_s),
    .dmem_en_s_i    (dmem_en_s),
    .rsrv_stall_s_i (rsrv_stall_s),
    .dx_stall_s_i   (dx_stall_s),
    .redirect_s_i   (redirect_s),
    .in_full_s_i    (in_full_s),
    .out_full_s_i   (out_full_s),
    .cnt_en_i       (cnt_en),
    .clr_i          (clr_s1),
    .inc_o          (inc),
    .clr_o          (clr_s2)
  );

  perf_counter_bank #(.cnt_w(cnt_w)) u_bank
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .inc_i      (inc),
    .clr_i      (clr_s2),
    .rd_id_i    (rd_id),
    .rd_count_o (rd_count)
  );

  perf_report_seq #(.cnt_w(cnt_w)) u_report
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dump_i      (dump_i),
    .rd_count_i  (rd_count),
    .rd_id_o     (rd_id),
    .rpt_v_o     (rpt_v_o),
    .rpt_id_o    (rpt_id_o),
    .rpt_count_o (rpt_count_o)
  );

endmodule

// File: src/perf_report_seq.sv
`timescale 1ns/1ps

module perf_report_seq
#(
  parameter int cnt_w = 32
)
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                dump_i,
  input  logic [cnt_w-1:0]    rd_count_i,
  output perf_pkg::perf_ctr_e rd_id_o,
  output logic                rpt_v_o,
  output perf_pkg::perf_ctr_e rpt_id_o,
  output logic [cnt_w-1:0]    rpt_count_o
);

  typedef enum logic
  {
    RPT_IDLE,
    RPT_SEND
  } rpt_state_e;

  rpt_state_e          state_q;
  perf_pkg::perf_ctr_e rd_id_q;

  assign rd_id_o = rd_id_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= RPT_IDLE;
      rd_id_q <= perf_pkg::CTR_CYCLES;
    end
    else
    begin
      case (state_q)
        RPT_IDLE:
        begin
          if (dump_i)
          begin
            state_q <= RPT_SEND;
            rd_id_q <= perf_pkg::CTR_CYCLES;
          end
        end
        RPT_SEND:
        begin
          rd_id_q <= perf_pkg::perf_ctr_e'(rd_id_q + 1'b1);
          if (rd_id_q == perf_pkg::CTR_OUT_FULL)
            state_q <= RPT_IDLE; // last counter sent
        end
        default: state_q <= RPT_IDLE;
      endcase
    end
  end

  // one beat per send cycle
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rpt_v_o <= 1'b0;
    else
      rpt_v_o <= (state_q == RPT_SEND);
  end

  always_ff @(posedge clk_i)
  begin
    rpt_id_o    <= rd_id_q;
    rpt_count_o <= rd_count_i; // live value of the indexed counter
  end

endmodule

// File: src/perf_counter_bank.sv
`timescale 1ns/1ps

module perf_counter_bank
#(
  parameter int cnt_w = 32
)
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [perf_pkg::NUM_CTRS-1:0] inc_i,
  input  logic                          clr_i,
  input  perf_pkg::perf_ctr_e           rd_id_i,
  output logic [cnt_w-1:0]              rd_count_o
);

  logic [cnt_w-1:0] cnt_q [perf_pkg::NUM_CTRS];

  // clear beats any increment in the same cycle
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || clr_i)
    begin
      for (int i = 0; i < perf_pkg::NUM_CTRS; i++)
      begin
        cnt_q[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < perf_pkg::NUM_CTRS; i++)
      begin
        if (inc_i[i])
          cnt_q[i] <= cnt_q[i] + 1'b1; // wraps
      end
    end
  end

  assign rd_count_o = cnt_q[rd_id_i];

endmodule

// File: src/perf_stall_classify.sv
`timescale 1ns/1ps

module perf_stall_classify
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          imem_wait_s_i,
  input  logic                          dmem_wait_s_i,
  input  logic                          dmem_en_s_i,
  input  logic                          rsrv_stall_s_i,
  input  logic                          dx_stall_s_i,
  input  logic                          redirect_s_i,
  input  logic                          in_full_s_i,
  input  logic                          out_full_s_i,
  input  logic                          cnt_en_i,
  input  logic                          clr_i,
  output logic [perf_pkg::NUM_CTRS-1:0] inc_o,
  output logic                          clr_o
);

  logic [perf_pkg::NUM_CTRS-1:0] inc_d;

  always_comb
  begin
    inc_d = '0;
    if (cnt_en_i)
    begin
      inc_d[perf_pkg::CTR_CYCLES]   = 1'b1;
      inc_d[perf_pkg::CTR_IMEM]     = imem_wait_s_i;
      inc_d[perf_pkg::CTR_IN_FULL]  = in_full_s_i;
      inc_d[perf_pkg::CTR_OUT_FULL] = out_full_s_i;
      // dmem wins the exclusive group
      if (dmem_wait_s_i && dmem_en_s_i)
        inc_d[perf_pkg::CTR_DMEM] = 1'b1;
      else if (rsrv_stall_s_i)
        inc_d[perf_pkg::CTR_RSRV] = 1'b1;
      else if (dx_stall_s_i)
        inc_d[perf_pkg::CTR_DX] = 1'b1;
      else if (redirect_s_i)
        inc_d[perf_pkg::CTR_REDIRECT] = 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      inc_o <= '0;
      clr_o <= 1'b0;
    end
    else
    begin
      inc_o <= inc_d;
      clr_o <= clr_i; // keeps clear aligned with inc
    end
  end

endmodule

// File: src/perf_event_sample.sv
`timescale 1ns/1ps

module perf_event_sample
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic freeze_i,
  input  logic imem_wait_i,
  input  logic dmem_wait_i,
  input  logic dmem_en_i,
  input  logic rsrv_stall_i,
  input  logic dx_stall_i,
  input  logic redirect_i,
  input  logic in_full_i,
  input  logic out_full_i,
  output logic imem_wait_s_o,
  output logic dmem_wait_s_o,
  output logic dmem_en_s_o,
  output logic rsrv_stall_s_o,
  output logic dx_stall_s_o,
  output logic redirect_s_o,
  output logic in_full_s_o,
  output logic out_full_s_o,
  output logic cnt_en_o,
  output logic clr_o
);

  logic freeze_q; // freeze from the previous edge
  logic clr_d;

  assign clr_d = freeze_q & ~freeze_i; // falling edge of freeze

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      freeze_q <= 1'b1; // first unfreeze after reset clears too
      cnt_en_o <= 1'b0;
      clr_o    <= 1'b0;
    end
    else
    begin
      freeze_q <= freeze_i;
      cnt_en_o <= ~freeze_i & ~clr_d; // clear cycle is not counted
      clr_o    <= clr_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    imem_wait_s_o  <= imem_wait_i;
    dmem_wait_s_o  <= dmem_wait_i;
    dmem_en_s_o    <= dmem_en_i;
    rsrv_stall_s_o <= rsrv_stall_i;
    dx_stall_s_o   <= dx_stall_i;
    redirect_s_o   <= redirect_i;
    in_full_s_o    <= in_full_i;
    out_full_s_o   <= out_full_i;
  end

endmodule

// File: src/perf_pkg.sv
package perf_pkg;

  localparam int NUM_CTRS      = 8;
  localparam int CTR_ID_W      = 3;
  localparam int CNT_W_DEFAULT = 32;

  // counter ids in readout order
  typedef enum logic [CTR_ID_W-1:0]
  {
    CTR_CYCLES   = 3'd0, // non-frozen cycles
    CTR_DMEM     = 3'd1,
    CTR_RSRV     = 3'd2,
    CTR_DX       = 3'd3,
    CTR_REDIRECT = 3'd4,
    CTR_IMEM     = 3'd5,
    CTR_IN_FULL  = 3'd6, // input buffer full
    CTR_OUT_FULL = 3'd7  // output buffer full
  } perf_ctr_e;

endpackage
